// ==== run.sh ====
#!/bin/sh
# Build and run the compressor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module bdiCompressor_tb -f tb.f -o simv \
    || { echo "Build failed"; exit 1; }

result=$(./obj_dir/simv)
echo "$result"
echo "$result" | grep -qx "Test OK" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+verilog
verilog/bdiPkg.sv
verilog/baseDeltaEncoder.sv
verilog/encodingSelector.sv
verilog/bdiCompressor.sv
test/bdiCompressor_asserts.sv
test/bdiCompressor_tb.sv

// ==== test/bdiCompressor_asserts.sv ====
`include "bdi_cfg.svh"

module bdiCompressor_asserts
(
    input logic             clk,
    input logic             rstN,
    input logic             lineValid,
    input bdiPkg::lineT     lineData,
    input logic             compValid,
    input bdiPkg::lineT     compData,
    input bdiPkg::encodingT compEnc,
    input bdiPkg::lenT      compLen
);

    bdiPkg::lenT tableLen;

    // Length table per encoding
    always_comb
    begin
        case (compEnc)
            bdiPkg::base8Delta1: tableLen = 6'd12;
            bdiPkg::base8Delta2: tableLen = 6'd16;
            bdiPkg::base8Delta4: tableLen = 6'd24;
            bdiPkg::base4Delta1: tableLen = 6'd12;
            bdiPkg::base4Delta2: tableLen = 6'd20;
            default: tableLen = 6'd32;
        endcase
    end

    strobeLatency: assert property (@(posedge clk) disable iff (!rstN)
        compValid == $past(lineValid, `BDI_LATENCY))
        else $error("compValid does not follow lineValid by %0d cycles", `BDI_LATENCY);

    lengthMatch: assert property (@(posedge clk) disable iff (!rstN)
        compValid |-> compLen == tableLen)
        else $error("compLen %0d does not match encoding %0d", compLen, compEnc);

    rawPassThrough: assert property (@(posedge clk) disable iff (!rstN)
        (compValid && compEnc == bdiPkg::uncompressed) |-> compData == $past(lineData, `BDI_LATENCY))
        else $error("Uncompressed output differs from its input line");

endmodule

bind bdiCompressor bdiCompressor_asserts asserts
(
    .clk       (clk),
    .rstN      (rstN),
    .lineValid (lineValid),
    .lineData  (lineData),
    .compValid (compValid),
    .compData  (compData),
    .compEnc   (compEnc),
    .compLen   (compLen)
);

// ==== test/bdiCompressor_tb.sv ====
`include "bdi_cfg.svh"

module bdiCompressor_tb;

    localparam int ClockPeriod = 20;
    localparam int DriveDelay = 2;
    localparam int ResetCycles = 10;
    localparam int NumCycles = 600;
    localparam int MarginCycles = 60;

    logic clk;
    logic rstN;
    logic lineValid;
    bdiPkg::lineT lineData;
    logic compValid;
    bdiPkg::lineT compData;
    bdiPkg::encodingT compEnc;
    bdiPkg::lenT compLen;

    logic [31:0] lfsrState;
    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;
    int encCount [6] = '{default: 0};

    // Expected results in input order
    bdiPkg::encodingT expEncQ [$];
    bdiPkg::lineT expDataQ [$];
    bdiPkg::lenT expLenQ [$];
    int expEdgeQ [$];

    bdiPkg::encodingT wantEnc;
    bdiPkg::lineT wantData;
    bdiPkg::lenT wantLen;
    int wantEdge;

    bdiCompressor uut
    (
        .clk       (clk),
        .rstN      (rstN),
        .lineValid (lineValid),
        .lineData  (lineData),
        .compValid (compValid),
        .compData  (compData),
        .compEnc   (compEnc),
        .compLen   (compLen)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    //////////////////////////////////////////////////
    // Fibonacci LFSR with taps 32 22 2 1

    function automatic logic [63:0] randomBits(input int count);
        logic [63:0] bits;
        logic feedback;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            bits = {bits[62:0], feedback};
        end
        return bits;
    endfunction

    // Random delta sign-extended to 64 bits
    function automatic logic [63:0] randomDelta(input int deltaBits);
        logic [63:0] delta;
        delta = randomBits(deltaBits);
        if (delta[deltaBits-1])
            delta = delta | ~((64'd1 << deltaBits) - 64'd1);
        return delta;
    endfunction

    task automatic makeLine(output bdiPkg::lineT line);
        logic [63:0] cls;
        logic [63:0] base64;
        logic [63:0] bits;
        logic [31:0] base32;
        logic [63:0] delta;
        cls = randomBits(3);
        line = '0;
        case (cls)
            64'd0, 64'd1, 64'd2:
            begin
                base64 = randomBits(64);
                line[63:0] = base64;
                for (int k = 1; k < 4; k++)
                begin
                    delta = randomDelta(8 << cls);
                    line[k*64 +: 64] = base64 + delta;
                end
            end
            64'd3, 64'd4:
            begin
                bits = randomBits(32);
                base32 = bits[31:0];
                line[31:0] = base32;
                for (int k = 1; k < 8; k++)
                begin
                    delta = randomDelta((cls == 64'd3) ? 8 : 16);
                    line[k*32 +: 32] = base32 + delta[31:0];
                end
            end
            default:
            begin
                for (int k = 0; k < 4; k++)
                    line[k*64 +: 64] = randomBits(64);
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Reference model

    // Word k minus word 0 wrapped to the word size and sign-extended
    function automatic longint wordDiff(input bdiPkg::lineT line, input int wordBits,
                                        input int k);
        logic [63:0] word;
        logic [63:0] diff;
        word = 64'(line >> (k * wordBits));
        diff = word - line[63:0];
        if (wordBits == 32)
            diff = {{32{diff[31]}}, diff[31:0]};
        return longint'(diff);
    endfunction

    function automatic logic widthFits(input bdiPkg::lineT line, input int wordBits,
                                       input int deltaBits);
        longint diff;
        longint limit;
        logic ok;
        ok = 1'b1;
        limit = longint'(1) <<< (deltaBits - 1);
        for (int k = 1; k < `BDI_LINE_BITS / wordBits; k++)
        begin
            diff = wordDiff(line, wordBits, k);
            if (diff < -limit || diff >= limit)
                ok = 1'b0;
        end
        return ok;
    endfunction

    function automatic bdiPkg::lineT packLine(input bdiPkg::lineT line, input int wordBits,
                                              input int deltaBits);
        bdiPkg::lineT result;
        bdiPkg::lineT slotMask;
        bdiPkg::lineT slot;
        slotMask = (bdiPkg::lineT'(1) << deltaBits) - bdiPkg::lineT'(1);
        result = line & ((bdiPkg::lineT'(1) << wordBits) - bdiPkg::lineT'(1));
        // Slot 0 stays zero
        for (int k = 1; k < `BDI_LINE_BITS / wordBits; k++)
        begin
            slot = bdiPkg::lineT'(wordDiff(line, wordBits, k)) & slotMask;
            result = result | (slot << (wordBits + k * deltaBits));
        end
        return result;
    endfunction

    task automatic predict(input bdiPkg::lineT line, output bdiPkg::encodingT enc,
                           output bdiPkg::lineT data, output bdiPkg::lenT len);
        enc = bdiPkg::uncompressed;
        data = line;
        len = 6'd32;
        if (widthFits(line, 64, 8))
        begin
            enc = bdiPkg::base8Delta1;
            data = packLine(line, 64, 8);
            len = 6'd12;
        end
        else if (widthFits(line, 64, 16))
        begin
            enc = bdiPkg::base8Delta2;
            data = packLine(line, 64, 16);
            len = 6'd16;
        end
        else if (widthFits(line, 64, 32))
        begin
            enc = bdiPkg::base8Delta4;
            data = packLine(line, 64, 32);
            len = 6'd24;
        end
        else if (widthFits(line, 32, 8))
        begin
            enc = bdiPkg::base4Delta1;
            data = packLine(line, 32, 8);
            len = 6'd12;
        end
        else if (widthFits(line, 32, 16))
        begin
            enc = bdiPkg::base4Delta2;
            data = packLine(line, 32, 16);
            len = 6'd20;
        end
    endtask

    task automatic driveCycle();
        logic [63:0] strobeBits;
        bdiPkg::lineT line;
        bdiPkg::encodingT enc;
        bdiPkg::lineT data;
        bdiPkg::lenT len;
        strobeBits = randomBits(2);
        makeLine(line);
        lineValid = (strobeBits != 64'd0);
        lineData = line;
        if (lineValid)
        begin
            predict(line, enc, data, len);
            expEncQ.push_back(enc);
            expDataQ.push_back(data);
            expLenQ.push_back(len);
            // Taken at the next edge and sampled out LATENCY edges after that
            expEdgeQ.push_back(cycleCount + 1 + `BDI_LATENCY);
        end
    endtask

    //////////////////////////////////////////////////
    // Output checks on the falling edge

    task automatic reportMismatch(input string testName, input bdiPkg::lineT expected,
                                  input bdiPkg::lineT actual);
        $display("[FAIL] %s line %0d expected %0h actual %0h",
                 testName, checkCount, expected, actual);
        errorCount++;
    endtask

    always @(negedge clk)
    begin
        if (!rstN && compValid)
        begin
            $display("compValid is high during reset");
            errorCount++;
        end
        else if (compValid && expEncQ.size() == 0)
        begin
            $display("compValid came high at cycle %0d with no line outstanding", cycleCount);
            errorCount++;
        end
        else if (compValid)
        begin
            wantEnc = expEncQ.pop_front();
            wantData = expDataQ.pop_front();
            wantLen = expLenQ.pop_front();
            wantEdge = expEdgeQ.pop_front();
            checkCount++;
            encCount[int'(wantEnc)]++;
            // compValid is sampled at the coming edge
            if (cycleCount + 1 != wantEdge)
                reportMismatch("latency", bdiPkg::lineT'(wantEdge),
                               bdiPkg::lineT'(cycleCount + 1));
            if (compEnc !== wantEnc)
                reportMismatch({"encoding ", wantEnc.name()}, bdiPkg::lineT'(wantEnc),
                               bdiPkg::lineT'(compEnc));
            if (compData !== wantData)
                reportMismatch("data", wantData, compData);
            if (compLen !== wantLen)
                reportMismatch("length", bdiPkg::lineT'(wantLen), bdiPkg::lineT'(compLen));
        end
    end

    //////////////////////////////////////////////////
    // Sequence and watchdog

    initial
    begin
        lfsrState = 32'd77763;
        rstN = 1'b0;
        lineValid = 1'b0;
        lineData = '0;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rstN = 1'b1;
        for (int n = 0; n < NumCycles; n++)
        begin
            @(posedge clk);
            #DriveDelay;
            driveCycle();
        end
        @(posedge clk);
        #DriveDelay;
        lineValid = 1'b0;
        while (expEncQ.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Lines %0d, errors %0d; b8d1 %0d b8d2 %0d b8d4 %0d b4d1 %0d b4d2 %0d raw %0d",
                 checkCount, errorCount, encCount[0], encCount[1], encCount[2],
                 encCount[3], encCount[4], encCount[5]);
        if (errorCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        #((ResetCycles + NumCycles + MarginCycles) * ClockPeriod);
        $display("Watchdog expired with %0d lines still outstanding", expEncQ.size());
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog/baseDeltaEncoder.sv ====
`include "bdi_cfg.svh"

module baseDeltaEncoder
#(
    parameter type wordT = logic [63:0],
    localparam int WordBits = $bits(wordT),
    localparam int WordCount = `BDI_LINE_BITS / WordBits,
    // Delta widths 1, 2, ... bytes up to half a word
    localparam int DeltaCount = $clog2(WordBits / `BDI_BYTE_BITS)
)
(
    input  logic         clk,
    input  logic         rstN,
    input  bdiPkg::lineT lineData,
    output logic [DeltaCount-1:0] fits,
    output bdiPkg::lineT packedLine [DeltaCount]
);

    wordT base;
    wordT deltas [WordCount];

    logic [DeltaCount-1:0] fitNext;
    bdiPkg::lineT packNext [DeltaCount];

    //////////////////////////////////////////////////
    // Wrapping differences against word 0

    assign base = lineData[WordBits-1:0];

    for (genvar k = 0; k < WordCount; k++)
    begin : gWord
        assign deltas[k] = lineData[k*WordBits +: WordBits] - base;
    end

    //////////////////////////////////////////////////
    // Fit test and packing, one per delta width

    for (genvar d = 0; d < DeltaCount; d++)
    begin : gDelta
        localparam int DeltaBits = `BDI_BYTE_BITS << d;

        logic [WordCount-1:0] wordFit;
        logic [WordCount*DeltaBits-1:0] deltaField;

        for (genvar k = 0; k < WordCount; k++)
        begin : gSlot
            logic [WordBits-DeltaBits:0] upper;

            // Sign extension holds when the top bits are all copies of the delta MSB
            assign upper = deltas[k][WordBits-1:DeltaBits-1];
            assign wordFit[k] = (&upper) | ~(|upper);

            if (k == 0)
            begin : gZero
                // Word 0 is the base itself
                assign deltaField[DeltaBits-1:0] = '0;
            end
            else
            begin : gTrunc
                assign deltaField[k*DeltaBits +: DeltaBits] = deltas[k][DeltaBits-1:0];
            end
        end

        assign fitNext[d] = &wordFit;

        // Base low, then the delta slots, then zero padding
        assign packNext[d] = bdiPkg::lineT'({deltaField, base});
    end

    //////////////////////////////////////////////////
    // Output registers

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            fits <= '0;
            packedLine <= '{default: '0};
        end
        else
        begin
            fits <= fitNext;
            packedLine <= packNext;
        end
    end

endmodule

// ==== verilog/bdiCompressor.sv ====
module bdiCompressor
(
    input  logic             clk,
    input  logic             rstN,
    input  logic             lineValid,
    input  bdiPkg::lineT     lineData,
    output logic             compValid,
    output bdiPkg::lineT     compData,
    output bdiPkg::encodingT compEnc,
    output bdiPkg::lenT      compLen
);

    // Encoder results, one cycle behind lineData
    logic [2:0]   fits8;
    bdiPkg::lineT packed8 [3];
    logic [1:0]   fits4;
    bdiPkg::lineT packed4 [2];

    baseDeltaEncoder #(.wordT(logic [63:0])) encoder8
    (
        .clk        (clk),
        .rstN       (rstN),
        .lineData   (lineData),
        .fits       (fits8),
        .packedLine (packed8)
    );

    baseDeltaEncoder #(.wordT(logic [31:0])) encoder4
    (
        .clk        (clk),
        .rstN       (rstN),
        .lineData   (lineData),
        .fits       (fits4),
        .packedLine (packed4)
    );

    encodingSelector selector
    (
        .clk       (clk),
        .rstN      (rstN),
        .lineValid (lineValid),
        .lineData  (lineData),
        .fits8     (fits8),
        .packed8   (packed8),
        .fits4     (fits4),
        .packed4   (packed4),
        .compValid (compValid),
        .compData  (compData),
        .compEnc   (compEnc),
        .compLen   (compLen)
    );

endmodule

// ==== verilog/bdiPkg.sv ====
`include "bdi_cfg.svh"

package bdiPkg;

    // One uncompressed or packed cache line
    typedef logic [`BDI_LINE_BITS-1:0] lineT;

    // Listed in priority order, first fitting one wins
    typedef enum logic [2:0]
    {
        base8Delta1,
        base8Delta2,
        base8Delta4,
        base4Delta1,
        base4Delta2,
        uncompressed
    } encodingT;

    // Compressed size in bytes, 0 to 32
    typedef logic [5:0] lenT;

endpackage

// ==== verilog/bdi_cfg.svh ====
`ifndef BDI_CFG_SVH
`define BDI_CFG_SVH

// Cache line geometry
`define BDI_LINE_BITS 256
`define BDI_BYTE_BITS 8

// Input strobe to output strobe, in cycles
`define BDI_LATENCY 2

`endif

// ==== verilog/encodingSelector.sv ====
`include "bdi_cfg.svh"

module encodingSelector
(
    input  logic             clk,
    input  logic             rstN,
    input  logic             lineValid,
    input  bdiPkg::lineT     lineData,
    input  logic [2:0]       fits8,
    input  bdiPkg::lineT     packed8 [3],
    input  logic [1:0]       fits4,
    input  bdiPkg::lineT     packed4 [2],
    output logic             compValid,
    output bdiPkg::lineT     compData,
    output bdiPkg::encodingT compEnc,
    output bdiPkg::lenT      compLen
);

    localparam int LineBytes = `BDI_LINE_BITS / `BDI_BYTE_BITS;

    logic validQ;
    bdiPkg::lineT lineQ;

    bdiPkg::encodingT encNext;
    bdiPkg::lineT dataNext;

    // Base bytes plus one delta per word
    function automatic bdiPkg::lenT lenOf(input bdiPkg::encodingT enc);
        int baseBytes;
        int deltaBytes;
        baseBytes = (enc inside {bdiPkg::base4Delta1, bdiPkg::base4Delta2}) ? 4 : 8;
        case (enc)
            bdiPkg::base8Delta1, bdiPkg::base4Delta1: deltaBytes = 1;
            bdiPkg::base8Delta2, bdiPkg::base4Delta2: deltaBytes = 2;
            bdiPkg::base8Delta4: deltaBytes = 4;
            default: deltaBytes = 0;
        endcase
        if (enc == bdiPkg::uncompressed)
            return bdiPkg::lenT'(LineBytes);
        return bdiPkg::lenT'(baseBytes + (LineBytes / baseBytes) * deltaBytes);
    endfunction

    //////////////////////////////////////////////////
    // Stage 1, aligned with the encoder registers

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            validQ <= 1'b0;
            lineQ <= '0;
        end
        else
        begin
            validQ <= lineValid;
            lineQ <= lineData;
        end
    end

    // 8-byte base first, narrow deltas before wide ones
    always_comb
    begin
        encNext = bdiPkg::uncompressed;
        dataNext = lineQ;
        if (fits8[0])
        begin
            encNext = bdiPkg::base8Delta1;
            dataNext = packed8[0];
        end
        else if (fits8[1])
        begin
            encNext = bdiPkg::base8Delta2;
            dataNext = packed8[1];
        end
        else if (fits8[2])
        begin
            encNext = bdiPkg::base8Delta4;
            dataNext = packed8[2];
        end
        else if (fits4[0])
        begin
            encNext = bdiPkg::base4Delta1;
            dataNext = packed4[0];
        end
        else if (fits4[1])
        begin
            encNext = bdiPkg::base4Delta2;
            dataNext = packed4[1];
        end
    end

    //////////////////////////////////////////////////
    // Stage 2 outputs

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            compValid <= 1'b0;
            compData <= '0;
            compEnc <= bdiPkg::encodingT'('0);
            compLen <= '0;
        end
        else
        begin
            compValid <= validQ;
            compData <= dataNext;
            compEnc <= encNext;
            compLen <= lenOf(encNext);
        end
    end

endmodule
